// File: all.f
vv_pkg.sv
vv_regfile.sv
vv_issue.sv
vv_block.sv
vv_readout.sv
vv_column.sv
tb_vv_column.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timescale 1ns/100ps
TOP       ?= tb_vv_column
FILELIST  ?= all.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

// File: tb_vv_column.sv
module tb_vv_column;
  timeunit 1ns;
  timeprecision 100ps;
  import vv_pkg::*;

  logic clk = 1'b0;
  logic rst_n;
  logic ext_save, int_save, int_sel, act_lookup_en, act_sel, act_en;
  logic sel_all, sel_en, sel_op, oreg_en, vec_load_sel, vec_load_en, vec_shift;
  word_t ext_data, shift_in, ext_data_out, vec_out;
  rf_addr_t addr_a, addr_b;
  act_code_t act_code;
  block_id_t sel_id, rd_id;
  alu_op_e alu_op;
  logic [NUM_BLOCKS-1:0] sel_active;

  word_t model [NUM_BLOCKS][RF_DEPTH];  // reference copy of every register file
  word_t vec_model [NUM_BLOCKS];
  logic [NUM_BLOCKS-1:0] sel_model;
  logic [31:0] seed = 32'hc8c4;
  int errors = 0;

  vv_column vv_column_i (.*);

  always #10 clk = ~clk;  // 20 ns period

  function automatic word_t next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;  // lcg
    return seed[31:16];
  endfunction

  // expected alu result straight from the opcode rules
  function automatic word_t alu_ref(alu_op_e op, word_t a, word_t b, word_t act);
    logic signed [31:0] p;
    p = $signed(a) * $signed(b);
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_MUL: return p[23:8];
      default: return act + p[23:8];  // mac
    endcase
  endfunction

  function automatic logic [7:0] act_row(word_t act);
    if (act[15:11] == 5'b00000 || act[15:11] == 5'b11111)
      return act[11:4];
    else if (act[15])
      return 8'd128;  // negative saturation
    else
      return 8'd127;
  endfunction

  task automatic check_word(word_t got, word_t exp, string what);
    if (got !== exp) begin
      errors++;
      $display("Error: time %0d ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_sel(logic [NUM_BLOCKS-1:0] got, logic [NUM_BLOCKS-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Error: time %0d ns: sel_active got %b expected %b", $time, got, exp);
    end
  endtask

  // one command slot, strobes drop after it
  task automatic step();
    @(negedge clk);
    ext_save = 0;
    int_save = 0;
    act_en = 0;
    sel_en = 0;
    oreg_en = 0;
    vec_load_en = 0;
    vec_shift = 0;
  endtask

  task automatic wait_sel(logic [NUM_BLOCKS-1:0] exp);
    int n;
    n = 0;
    while (sel_active !== exp && n < 20) begin
      @(negedge clk);
      n++;
    end
    check_sel(sel_active, exp);
  endtask

  task automatic write_word(rf_addr_t a, word_t d, logic only_sel);
    addr_a = a;
    ext_data = d;
    ext_save = 1;
    sel_op = only_sel;
    for (int b = 0; b < NUM_BLOCKS; b++)
      if (!only_sel || sel_model[b])
        model[b][a] = d;
    step();
  endtask

  task automatic read_check(int blk, rf_addr_t a);
    addr_a = a;
    rd_id = block_id_t'(blk);
    repeat (4) step();  // 3 edges of latency plus margin
    check_word(ext_data_out, model[blk][a], $sformatf("block %0d addr %0d", blk, a));
  endtask

  task automatic select(int id, logic all);
    sel_id = block_id_t'(id);
    sel_all = all;
    sel_en = 1;
    for (int b = 0; b < NUM_BLOCKS; b++)
      sel_model[b] = all || (b == id);
    step();
    wait_sel(sel_model);
  endtask

  task automatic load_act(word_t v);
    write_word(10'd20, v, 0);
    addr_a = 10'd20;
    step();
    act_en = 1;
    act_sel = 1;
    step();  // act from port a
  endtask

  task automatic run_alu(alu_op_e op, rf_addr_t dest);
    word_t xa, xb, r;
    xa = next_rand();
    xb = next_rand();
    write_word(10'd10, xa, 0);
    write_word(10'd11, xb, 0);
    if (op == ALU_MAC) begin
      addr_a = 10'd10;
      step();
      act_en = 1;
      act_sel = 1;
      step();
    end
    addr_a = 10'd10;
    addr_b = 10'd11;
    step();  // addresses one command early
    alu_op = op;
    oreg_en = 1;
    step();
    int_save = 1;
    int_sel = 0;
    addr_b = dest;
    step();
    r = alu_ref(op, xa, xb, xa);
    for (int b = 0; b < NUM_BLOCKS; b++)
      model[b][dest] = r;
    read_check(0, dest);
    read_check(NUM_BLOCKS - 1, dest);
  endtask

  task automatic run_lookup(word_t v, rf_addr_t dest);
    load_act(v);
    act_code = 2'd2;
    act_lookup_en = 1;
    step();
    vec_load_en = 1;
    vec_load_sel = 1;
    step();  // port b still on the table
    act_lookup_en = 0;
    int_save = 1;
    int_sel = 1;
    addr_b = dest;
    step();
    for (int b = 0; b < NUM_BLOCKS; b++)
      model[b][dest] = model[b][{2'd2, act_row(v)}];
    read_check(1, dest);
  endtask

  initial begin
    repeat (20000) @(posedge clk);
    $display("timeout, the test did not finish in time");
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    rst_n = 0;
    ext_save = 0;
    int_save = 0;
    int_sel = 0;
    act_lookup_en = 0;
    act_sel = 0;
    act_en = 0;
    sel_all = 0;
    sel_en = 0;
    sel_op = 0;
    oreg_en = 0;
    vec_load_sel = 0;
    vec_load_en = 0;
    vec_shift = 0;
    ext_data = '0;
    shift_in = '0;
    addr_a = '0;
    addr_b = '0;
    act_code = '0;
    sel_id = '0;
    rd_id = '0;
    alu_op = ALU_ADD;
    sel_model = '1;
    for (int i = 0; i < 10; i++)
      @(negedge clk);  // reset for 10 cycles
    rst_n = 1;
    step();
    // broadcast writes
    for (int a = 0; a < 5; a++)
      write_word(rf_addr_t'(a), next_rand(), 0);
    for (int b = 0; b < NUM_BLOCKS; b++)
      for (int a = 0; a < 5; a++)
        read_check(b, rf_addr_t'(a));
    rd_id = block_id_t'(NUM_BLOCKS);  // no such block
    repeat (4) step();
    check_word(ext_data_out, '0, "unused block id");
    // selection
    wait_sel('1);
    select(2, 0);
    write_word(10'd3, next_rand(), 1);
    for (int b = 0; b < NUM_BLOCKS; b++)
      read_check(b, 10'd3);
    write_word(10'd4, next_rand(), 0);  // sel_op low reaches unselected blocks too
    for (int b = 0; b < NUM_BLOCKS; b++)
      read_check(b, 10'd4);
    select(0, 1);
    // alu and internal saves
    run_alu(ALU_ADD, 10'd40);
    run_alu(ALU_SUB, 10'd41);
    run_alu(ALU_MUL, 10'd42);
    run_alu(ALU_MAC, 10'd43);
    // activation table in section 2
    for (int i = 512; i < 768; i++)
      if (i % 8 == 7 || i % 8 == 0)
        write_word(rf_addr_t'(i), next_rand(), 0);
    write_word({2'd2, 8'h23}, 16'h1234, 0);
    write_word({2'd2, 8'hf8}, 16'h5678, 0);
    run_lookup(16'h0230, 10'd50);  // middle, positive
    run_lookup(16'hff80, 10'd51);  // middle, negative
    run_lookup(16'h3000, 10'd52);  // positive saturation
    run_lookup(16'h9000, 10'd53);  // negative saturation
    // shift chain, one distinct word per block
    for (int b = 0; b < NUM_BLOCKS; b++) begin
      select(b, 0);
      vec_model[b] = next_rand();
      write_word(10'd30, vec_model[b], 1);
    end
    select(0, 1);
    addr_b = 10'd30;
    step();
    vec_load_en = 1;
    vec_load_sel = 1;
    step();
    repeat (3) step();
    check_word(vec_out, vec_model[NUM_BLOCKS-1], "vec_out before shift");
    for (int s = 0; s < 6; s++) begin
      shift_in = next_rand();
      vec_shift = 1;
      vec_load_en = 1;  // load ignored while shifting
      for (int b = NUM_BLOCKS - 1; b > 0; b--)
        vec_model[b] = vec_model[b-1];
      vec_model[0] = shift_in;
      repeat (4) step();
      check_word(vec_out, vec_model[NUM_BLOCKS-1], $sformatf("vec_out shift %0d", s));
    end
    $display("errors: %0d", errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

// File: vv_column.sv
module vv_column (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             ext_save,
  input  vv_pkg::word_t                    ext_data,
  input  logic                             int_save,
  input  logic                             int_sel,
  input  vv_pkg::rf_addr_t                 addr_a,
  input  vv_pkg::rf_addr_t                 addr_b,
  input  vv_pkg::act_code_t                act_code,
  input  logic                             act_lookup_en,
  input  logic                             act_sel,
  input  logic                             act_en,
  input  vv_pkg::block_id_t                sel_id,
  input  logic                             sel_all,
  input  logic                             sel_en,
  input  logic                             sel_op,
  input  vv_pkg::alu_op_e                  alu_op,
  input  logic                             oreg_en,
  input  logic                             vec_load_sel,
  input  logic                             vec_load_en,
  input  logic                             vec_shift,
  input  vv_pkg::word_t                    shift_in,
  input  vv_pkg::block_id_t                rd_id,
  output vv_pkg::word_t                    ext_data_out,
  output vv_pkg::word_t                    vec_out,
  output logic [vv_pkg::NUM_BLOCKS-1:0]    sel_active  // one bit per block
);
  import vv_pkg::*;

  // registered broadcast command
  logic      c_ext_save, c_int_save, c_int_sel, c_act_lookup_en, c_act_sel, c_act_en;
  logic      c_sel_all, c_sel_en, c_sel_op, c_oreg_en;
  logic      c_vec_load_sel, c_vec_load_en, c_vec_shift;
  word_t     c_ext_data;
  rf_addr_t  c_addr_a, c_addr_b;
  act_code_t c_act_code;
  block_id_t c_sel_id, c_rd_id;
  alu_op_e   c_alu_op;

  word_t [NUM_BLOCKS:0]   chain;     // chain[0] is the head, chain[NUM_BLOCKS] the top
  word_t [NUM_BLOCKS-1:0] port_a_w;

  // port names match the c_ nets one to one
  vv_issue issue_i (.*, .c_shift_in(chain[0]));

  for (genvar i = 0; i < NUM_BLOCKS; i++) begin : g_blk
    vv_block blk_i (
      .*,
      .block_id   (block_id_t'(i)),
      .par_in     (chain[i]),
      .par_out    (chain[i+1]),
      .port_a     (port_a_w[i]),
      .sel_active (sel_active[i])
    );
  end

  vv_readout readout_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .rd_id        (c_rd_id),
    .port_a_all   (port_a_w),
    .last_vec     (chain[NUM_BLOCKS]),
    .ext_data_out (ext_data_out),
    .vec_out      (vec_out)
  );

endmodule

// File: vv_readout.sv
module vv_readout (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  vv_pkg::block_id_t                        rd_id,
  input  vv_pkg::word_t [vv_pkg::NUM_BLOCKS-1:0]   port_a_all,  // one port-a word per block
  input  vv_pkg::word_t                            last_vec,    // top of the shift chain
  output vv_pkg::word_t                            ext_data_out,
  output vv_pkg::word_t                            vec_out
);
  import vv_pkg::*;

  word_t rd_word;

  // pick the addressed block
  always_comb begin
    rd_word = '0;  // unknown id reads zero
    for (int i = 0; i < NUM_BLOCKS; i++) begin
      if (rd_id == block_id_t'(i))
        rd_word = port_a_all[i];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ext_data_out <= '0;
      vec_out      <= '0;
    end else begin
      ext_data_out <= rd_word;
      vec_out      <= last_vec;  // one edge behind the last vector register
    end
  end

endmodule

// File: vv_block.sv
module vv_block (
  input  logic              clk,
  input  logic              rst_n,
  input  vv_pkg::block_id_t block_id,        // tied to the column position
  input  logic              c_ext_save,
  input  vv_pkg::word_t     c_ext_data,
  input  logic              c_int_save,
  input  logic              c_int_sel,
  input  vv_pkg::rf_addr_t  c_addr_a,
  input  vv_pkg::rf_addr_t  c_addr_b,
  input  vv_pkg::act_code_t c_act_code,
  input  logic              c_act_lookup_en,
  input  logic              c_act_sel,
  input  logic              c_act_en,
  input  vv_pkg::block_id_t c_sel_id,
  input  logic              c_sel_all,
  input  logic              c_sel_en,
  input  logic              c_sel_op,
  input  vv_pkg::alu_op_e   c_alu_op,
  input  logic              c_oreg_en,
  input  logic              c_vec_load_sel,
  input  logic              c_vec_load_en,
  input  logic              c_vec_shift,
  input  vv_pkg::word_t     par_in,          // vector word from the block below
  output vv_pkg::word_t     par_out,         // vector word to the block above
  output vv_pkg::word_t     port_a,
  output logic              sel_active
);
  import vv_pkg::*;

  logic     sel_q;        // selection bit
  word_t    oreg_q;       // alu output register
  word_t    act_q;        // activation register
  word_t    vec_q;        // vector register
  logic     we_a;
  rf_addr_t rf_addr_b;
  word_t    din_b;
  word_t    dout_a;
  word_t    dout_b;
  logic [TBL_ADDR_W-1:0] tbl_row;
  logic [4:0]            act_msb;
  logic signed [2*WORD_W-1:0] prod;
  word_t    prod_q88;
  word_t    alu_out;

  // external data goes in on port a, gated by selection only when sel_op is set
  assign we_a  = c_ext_save & (~c_sel_op | sel_q);
  assign din_b = c_int_sel ? vec_q : oreg_q;  // internal save source on port b

  // lookup replaces the port b address with {section, row}
  assign rf_addr_b = c_act_lookup_en ? {c_act_code, tbl_row} : c_addr_b;

  vv_regfile rf_i (
    .clk    (clk),
    .we_a   (we_a),
    .we_b   (c_int_save),
    .addr_a (c_addr_a),
    .addr_b (rf_addr_b),
    .din_a  (c_ext_data),
    .din_b  (din_b),
    .dout_a (dout_a),
    .dout_b (dout_b)
  );

  // activation value to table row
  assign act_msb = act_q[WORD_W-1 -: 5];  // range check bits

  always_comb begin
    if (act_msb == '0 || act_msb == '1)
      tbl_row = act_q[4 +: TBL_ADDR_W];              // non-linear region, middle bits
    else if (act_msb[4])
      tbl_row = TBL_ADDR_W'(1 << (TBL_ADDR_W - 1));  // negative saturation row 128
    else
      tbl_row = TBL_ADDR_W'((1 << (TBL_ADDR_W - 1)) - 1);  // positive saturation row 127
  end

  // q8.8 multiply keeps bits 23..8 of the full product
  assign prod     = $signed(dout_a) * $signed(dout_b);
  assign prod_q88 = prod[WORD_W/2 +: WORD_W];

  always_comb begin
    case (c_alu_op)
      ALU_ADD: alu_out = dout_a + dout_b;  // wraps at 16 bits
      ALU_SUB: alu_out = dout_a - dout_b;
      ALU_MUL: alu_out = prod_q88;
      ALU_MAC: alu_out = act_q + prod_q88;  // accumulate into the activation value
      default: alu_out = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sel_q  <= 1'b1;  // every block starts selected
      oreg_q <= '0;
      act_q  <= '0;
      vec_q  <= '0;
    end else begin
      if (c_sel_en)
        sel_q <= c_sel_all | (c_sel_id == block_id);
      if (c_oreg_en)
        oreg_q <= alu_out;
      if (c_act_en)
        act_q <= c_act_sel ? dout_a : oreg_q;
      // parallel shift wins over a load
      if (c_vec_shift)
        vec_q <= par_in;
      else if (c_vec_load_en)
        vec_q <= c_vec_load_sel ? dout_b : oreg_q;
    end
  end

  assign par_out    = vec_q;
  assign port_a     = dout_a;
  assign sel_active = sel_q;

endmodule

// File: vv_issue.sv
module vv_issue (
  input  logic              clk,
  input  logic              rst_n,
  // broadcast command from the top-level ports
  input  logic              ext_save,
  input  vv_pkg::word_t     ext_data,
  input  logic              int_save,
  input  logic              int_sel,
  input  vv_pkg::rf_addr_t  addr_a,
  input  vv_pkg::rf_addr_t  addr_b,
  input  vv_pkg::act_code_t act_code,
  input  logic              act_lookup_en,
  input  logic              act_sel,
  input  logic              act_en,
  input  vv_pkg::block_id_t sel_id,
  input  logic              sel_all,
  input  logic              sel_en,
  input  logic              sel_op,
  input  vv_pkg::alu_op_e   alu_op,
  input  logic              oreg_en,
  input  logic              vec_load_sel,
  input  logic              vec_load_en,
  input  logic              vec_shift,
  input  vv_pkg::word_t     shift_in,
  input  vv_pkg::block_id_t rd_id,
  // registered copies, fanned out to every block
  output logic              c_ext_save,
  output vv_pkg::word_t     c_ext_data,
  output logic              c_int_save,
  output logic              c_int_sel,
  output vv_pkg::rf_addr_t  c_addr_a,
  output vv_pkg::rf_addr_t  c_addr_b,
  output vv_pkg::act_code_t c_act_code,
  output logic              c_act_lookup_en,
  output logic              c_act_sel,
  output logic              c_act_en,
  output vv_pkg::block_id_t c_sel_id,
  output logic              c_sel_all,
  output logic              c_sel_en,
  output logic              c_sel_op,
  output vv_pkg::alu_op_e   c_alu_op,
  output logic              c_oreg_en,
  output logic              c_vec_load_sel,
  output logic              c_vec_load_en,
  output logic              c_vec_shift,
  output vv_pkg::word_t     c_shift_in,   // head of the shift chain
  output vv_pkg::block_id_t c_rd_id       // goes to the readout only
);
  import vv_pkg::*;

  // one pipeline stage to cut the broadcast fan-out
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      c_ext_save      <= 1'b0;  // strobes idle after reset
      c_ext_data      <= '0;
      c_int_save      <= 1'b0;
      c_int_sel       <= 1'b0;
      c_addr_a        <= '0;
      c_addr_b        <= '0;
      c_act_code      <= '0;
      c_act_lookup_en <= 1'b0;
      c_act_sel       <= 1'b0;
      c_act_en        <= 1'b0;
      c_sel_id        <= '0;
      c_sel_all       <= 1'b0;
      c_sel_en        <= 1'b0;
      c_sel_op        <= 1'b0;
      c_alu_op        <= ALU_ADD;
      c_oreg_en       <= 1'b0;
      c_vec_load_sel  <= 1'b0;
      c_vec_load_en   <= 1'b0;
      c_vec_shift     <= 1'b0;
      c_shift_in      <= '0;
      c_rd_id         <= '0;
    end else begin
      c_ext_save      <= ext_save;
      c_ext_data      <= ext_data;
      c_int_save      <= int_save;
      c_int_sel       <= int_sel;
      c_addr_a        <= addr_a;
      c_addr_b        <= addr_b;
      c_act_code      <= act_code;
      c_act_lookup_en <= act_lookup_en;
      c_act_sel       <= act_sel;
      c_act_en        <= act_en;
      c_sel_id        <= sel_id;
      c_sel_all       <= sel_all;
      c_sel_en        <= sel_en;
      c_sel_op        <= sel_op;
      c_alu_op        <= alu_op;
      c_oreg_en       <= oreg_en;
      c_vec_load_sel  <= vec_load_sel;
      c_vec_load_en   <= vec_load_en;
      c_vec_shift     <= vec_shift;
      c_shift_in      <= shift_in;
      c_rd_id         <= rd_id;
    end
  end

endmodule

// File: vv_regfile.sv
module vv_regfile (
  input  logic             clk,
  input  logic             we_a,
  input  logic             we_b,
  input  vv_pkg::rf_addr_t addr_a,
  input  vv_pkg::rf_addr_t addr_b,
  input  vv_pkg::word_t    din_a,
  input  vv_pkg::word_t    din_b,
  output vv_pkg::word_t    dout_a,
  output vv_pkg::word_t    dout_b
);
  import vv_pkg::*;

  word_t mem [RF_DEPTH];  // contents undefined after reset

  // both ports in one process so the array has a single writer
  always_ff @(posedge clk) begin
    if (we_a) mem[addr_a] <= din_a;
    if (we_b) mem[addr_b] <= din_b;  // port b wins on an address clash
    // write-first on each port, read data registered
    dout_a <= we_a ? din_a : mem[addr_a];
    dout_b <= we_b ? din_b : mem[addr_b];
  end

endmodule

// File: vv_pkg.sv
package vv_pkg;

  // data path widths, Q8.8 fixed point
  localparam int WORD_W     = 16;
  localparam int RF_DEPTH   = 1024;              // words per block register file
  localparam int RF_ADDR_W  = $clog2(RF_DEPTH);  // 10 bits
  localparam int TBL_ADDR_W = 8;                 // activation table row
  localparam int ACT_CODE_W = 2;                 // table section, sits above the row
  localparam int ID_W       = 4;
  localparam int NUM_BLOCKS = 4;                 // blocks stacked in the column

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [RF_ADDR_W-1:0]  rf_addr_t;
  typedef logic [ACT_CODE_W-1:0] act_code_t;
  typedef logic [ID_W-1:0]       block_id_t;

  // alu opcodes
  typedef enum logic [1:0] {
    ALU_ADD = 2'd0,  // a + b
    ALU_SUB = 2'd1,  // a - b
    ALU_MUL = 2'd2,  // q8.8 product of a and b
    ALU_MAC = 2'd3   // act + q8.8 product
  } alu_op_e;

endpackage
